// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tbZ80InstrDecoder
FILELIST := sources.f
BUILDDIR := obj_dir
LOG      := sim.log
PASSMSG  := NO ERRORS
RUNARGS  := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: compile
	./$(BUILDDIR)/V$(TOP) $(RUNARGS) | tee $(LOG)
	grep -q "^$(PASSMSG)$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== source/decodeResultRegs.sv ====
`timescale 1ns/1ps

module decodeResultRegs import z80DecodePkg::*; (
    input  logic                 pclk,
    input  logic                 rstN,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [addrWidth-1:0] paddr,
    input  logic [lenWidth-1:0]  byteCount,
    input  insnGroup             group,
    input  logic [lenWidth-1:0]  len,
    input  logic                 ackPulse,
    output logic [dataWidth-1:0] prdata,
    output logic                 done
);

    insnGroup            resGroup;
    logic [lenWidth-1:0] resLen;
    logic                complete;
    logic                resultRead;

    // enough bytes for the decoded length
    assign complete = !done && (byteCount != '0) && (byteCount >= len);

    always_ff @(posedge pclk) begin
        if (!rstN) begin
            done <= 1'b0;
        end else if (ackPulse) begin
            done <= 1'b0;
        end else if (complete) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge pclk) begin
        if (complete) begin
            resGroup <= group;
            resLen <= len;
        end
    end

    assign resultRead = psel && penable && !pwrite && (paddr == regResult);

    always_comb begin
        prdata = '0;
        if (resultRead) begin
            prdata[7:0] = resGroup;
            prdata[10:8] = resLen;
            prdata[16] = done;
        end
    end

endmodule

// ==== source/indexedClassifier.sv ====
`timescale 1ns/1ps

module indexedClassifier import z80DecodePkg::*; (
    input  logic [7:0]          byte1,
    input  logic [7:0]          byte3,
    output insnGroup            idxGroup,
    output logic [lenWidth-1:0] idxLen
);

    insnGroup bitsGroup;

    // the DD CB d op form keeps its operation in the fourth byte
    always_comb begin
        case (byte3) inside
            8'b000??110: bitsGroup = rotIdx;
            8'b0010?110, 8'h3E: bitsGroup = shiftIdx;
            8'b01???110: bitsGroup = bitIdx;
            8'b11???110: bitsGroup = setIdx;
            8'b10???110: bitsGroup = resIdx;
            default: bitsGroup = illegal;
        endcase
    end

    always_comb begin
        idxGroup = illegal;
        idxLen = 3'd2;
        case (byte1) inside
            8'b00??1001: idxGroup = addIxiySs;
            8'h23, 8'h2B: idxGroup = incDecIxiy;
            8'h21: begin
                idxGroup = ldIxiyNn;
                idxLen = 3'd4;
            end
            8'h2A: begin
                idxGroup = ldIxiyIndNn;
                idxLen = 3'd4;
            end
            8'h22: begin
                idxGroup = ldIndNnIxiy;
                idxLen = 3'd4;
            end
            8'h34, 8'h35: begin
                idxGroup = incDecIdx;
                idxLen = 3'd3;
            end
            8'h36: begin
                idxGroup = ldIdxN;
                idxLen = 3'd4;
            end
            8'b010??110, 8'b0110?110, 8'h7E: begin
                idxGroup = ldRegIdx;
                idxLen = 3'd3;
            end
            8'b011100??, 8'b0111010?, 8'h77: begin
                idxGroup = ldIdxReg;
                idxLen = 3'd3;
            end
            8'b10???110: begin
                idxGroup = aluAIdx;
                idxLen = 3'd3;
            end
            8'hE1: idxGroup = popIxiy;
            8'hE3: idxGroup = exIndSpIxiy;
            8'hE5: idxGroup = pushIxiy;
            8'hE9: idxGroup = jpIndIxiy;
            8'hF9: idxGroup = ldSpIxiy;
            prefixCb: begin
                idxGroup = bitsGroup;
                idxLen = 3'd4;
            end
            default: begin
                idxGroup = illegal;
                idxLen = 3'd2;
            end
        endcase
    end

endmodule

// ==== source/instrByteWindow.sv ====
`timescale 1ns/1ps

module instrByteWindow import z80DecodePkg::*; (
    input  logic                 pclk,
    input  logic                 rstN,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [addrWidth-1:0] paddr,
    input  logic [dataWidth-1:0] pwdata,
    input  logic                 done,
    output logic                 pready,
    output logic                 pslverr,
    output logic [7:0]           byte0,
    output logic [7:0]           byte1,
    output logic [7:0]           byte3,
    output logic [lenWidth-1:0]  byteCount,
    output logic                 ackPulse
);

    logic [7:0] window [windowBytes];
    logic       writeAccess;
    logic       byteWrite;
    logic       windowFull;
    logic       byteAccept;
    logic       unmapped;

    // zero wait states
    assign pready = 1'b1;

    assign writeAccess = psel && penable && pwrite;
    assign byteWrite = writeAccess && (paddr == regByte);
    assign ackPulse = writeAccess && (paddr == regAck);
    assign unmapped = writeAccess && (paddr != regByte) && (paddr != regAck);

    assign windowFull = (byteCount == lenWidth'(windowBytes));

    // no new bytes while a result is pending or the window is full
    assign byteAccept = byteWrite && !done && !windowFull;
    assign pslverr = unmapped || (byteWrite && (done || windowFull));

    always_ff @(posedge pclk) begin
        if (byteAccept) begin
            window[byteCount[1:0]] <= pwdata[7:0];
        end
    end

    always_ff @(posedge pclk) begin
        if (!rstN) begin
            byteCount <= '0;
        end else if (ackPulse) begin
            byteCount <= '0;
        end else if (byteAccept) begin
            byteCount <= byteCount + lenWidth'(1);
        end
    end

    // byte 2 is only a displacement or an operand
    assign byte0 = window[0];
    assign byte1 = window[1];
    assign byte3 = window[3];

endmodule

// ==== source/instrClassifier.sv ====
`timescale 1ns/1ps

module instrClassifier import z80DecodePkg::*; (
    input  logic [7:0]          byte0,
    input  logic [7:0]          byte1,
    input  logic [7:0]          byte3,
    output insnGroup            group,
    output logic [lenWidth-1:0] len
);

    insnGroup            idxGroup;
    logic [lenWidth-1:0] idxLen;

    indexedClassifier uIndexed (
        .byte1    (byte1),
        .byte3    (byte3),
        .idxGroup (idxGroup),
        .idxLen   (idxLen)
    );

    always_comb begin
        group = illegal;
        len = 3'd1;
        case (byte0) inside
            prefixCb: begin
                len = 3'd2;
                case (byte1) inside
                    8'b000??110: group = rotIndHl;
                    8'b000?????: group = rotReg;
                    8'b0010?110, 8'b00111110: group = shiftIndHl;
                    8'b0010????, 8'b00111???: group = shiftReg;
                    8'b01???110: group = bitIndHl;
                    8'b01??????: group = bitReg;
                    8'b11???110: group = setIndHl;
                    8'b11??????: group = setReg;
                    8'b10???110: group = resIndHl;
                    8'b10??????: group = resReg;
                    // 0x30..0x37 is left undocumented
                    default: group = illegal;
                endcase
            end
            prefixDd, prefixFd: begin
                group = idxGroup;
                len = idxLen;
            end
            prefixEd: begin
                group = edUnsupported;
                len = 3'd2;
            end
            8'h00: group = nop;
            8'h02, 8'h12: group = ldIndBcdeA;
            8'h0A, 8'h1A: group = ldAIndBcde;
            8'h08: group = exAfAf2;
            8'h10: begin group = djnz; len = 3'd2; end
            8'h18: begin group = jr; len = 3'd2; end
            8'b001??000: begin group = jrCond; len = 3'd2; end
            8'h22: begin group = ldIndNnHl; len = 3'd3; end
            8'h2A: begin group = ldHlIndNn; len = 3'd3; end
            8'h32: begin group = ldIndNnA; len = 3'd3; end
            8'h3A: begin group = ldAIndNn; len = 3'd3; end
            8'h27: group = daa;
            8'h2F: group = cpl;
            8'h37: group = scf;
            8'h3F: group = ccf;
            8'h34, 8'h35: group = incDecIndHl;
            8'h36: begin group = ldIndHlN; len = 3'd2; end
            8'b00??0001: begin group = ldDdNn; len = 3'd3; end
            8'b00??0011, 8'b00??1011: group = incDecDd;
            8'b00??1001: group = addHlDd;
            8'b000??111: group = rotA;
            8'b00???10?: group = incDecReg;
            8'b00???110: begin group = ldRegN; len = 3'd2; end
            8'h76: group = halt;
            8'b01110???: group = ldIndHlReg;
            // ld r,(hl) has no group of its own and stays illegal
            8'b01???0??, 8'b01???10?, 8'b01???111: group = ldRegReg;
            8'b10???110: group = aluAIndHl;
            8'b10??????: group = aluAReg;
            8'hC3: begin group = jp; len = 3'd3; end
            8'hCD: begin group = call; len = 3'd3; end
            8'hC9: group = ret;
            8'hE9: group = jpIndHl;
            8'hE3: group = exIndSpHl;
            8'hEB: group = exDeHl;
            8'hD9: group = exx;
            8'hF9: group = ldSpHl;
            8'hF3, 8'hFB: group = eiDi;
            8'b11???010: begin group = jpCond; len = 3'd3; end
            8'b11???100: begin group = callCond; len = 3'd3; end
            8'b11???000: group = retCond;
            8'b11??0001: group = popQq;
            8'b11??0101: group = pushQq;
            8'b11???110: begin group = aluAN; len = 3'd2; end
            default: begin
                group = illegal;
                len = 3'd1;
            end
        endcase
    end

endmodule

// ==== source/z80DecodePkg.sv ====
package z80DecodePkg;

    // window and bus geometry
    localparam int windowBytes = 4;
    localparam int lenWidth = 3;
    localparam int dataWidth = 32;
    localparam int addrWidth = 4;

    localparam logic [7:0] prefixCb = 8'hCB;
    localparam logic [7:0] prefixDd = 8'hDD;
    localparam logic [7:0] prefixEd = 8'hED;
    localparam logic [7:0] prefixFd = 8'hFD;

    typedef enum logic [addrWidth-1:0] {
        regByte = 4'h0,
        regResult = 4'h4,
        regAck = 4'h8
    } apbReg;

    typedef enum logic [7:0] {
        // unprefixed
        nop, ldDdNn, ldIndBcdeA, incDecDd, incDecReg,
        rotA, addHlDd, daa, cpl, incDecIndHl,
        ldAIndBcde, ldRegN, ldIndNnHl, ldHlIndNn, ldIndHlN,
        ldRegReg, ldIndNnA, scf, ldAIndNn, ccf,
        ldIndHlReg, halt, jp, jpCond, jpIndHl,
        jr, jrCond, djnz, call, callCond,
        ret, retCond, popQq, pushQq, exAfAf2,
        exIndSpHl, exDeHl, exx, ldSpHl, aluAReg,
        aluAIndHl, aluAN, eiDi,
        // CB page
        rotReg, rotIndHl, shiftReg, shiftIndHl, bitReg,
        bitIndHl, setReg, setIndHl, resReg, resIndHl,
        // DD/FD page
        addIxiySs, incDecIxiy, ldRegIdx, ldIdxReg, ldIxiyNn,
        ldIxiyIndNn, incDecIdx, ldIdxN, exIndSpIxiy, popIxiy,
        pushIxiy, ldIndNnIxiy, aluAIdx, jpIndIxiy, ldSpIxiy,
        rotIdx, shiftIdx, bitIdx, setIdx, resIdx,
        edUnsupported,
        illegal
    } insnGroup;

endpackage

// ==== source/z80InstrDecoderTop.sv ====
`timescale 1ns/1ps

module z80InstrDecoderTop import z80DecodePkg::*; (
    input  logic                 pclk,
    input  logic                 rstN,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [addrWidth-1:0] paddr,
    input  logic [dataWidth-1:0] pwdata,
    output logic [dataWidth-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr
);

    logic [7:0]          byte0;
    logic [7:0]          byte1;
    logic [7:0]          byte3;
    logic [lenWidth-1:0] byteCount;
    logic [lenWidth-1:0] len;
    insnGroup            group;
    logic                done;
    logic                ackPulse;

    instrByteWindow uWindow (
        .pclk      (pclk),
        .rstN      (rstN),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .done      (done),
        .pready    (pready),
        .pslverr   (pslverr),
        .byte0     (byte0),
        .byte1     (byte1),
        .byte3     (byte3),
        .byteCount (byteCount),
        .ackPulse  (ackPulse)
    );

    instrClassifier uClassifier (
        .byte0 (byte0),
        .byte1 (byte1),
        .byte3 (byte3),
        .group (group),
        .len   (len)
    );

    decodeResultRegs uResult (
        .pclk      (pclk),
        .rstN      (rstN),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .byteCount (byteCount),
        .group     (group),
        .len       (len),
        .ackPulse  (ackPulse),
        .prdata    (prdata),
        .done      (done)
    );

endmodule

// ==== sources.f ====
source/z80DecodePkg.sv
source/instrByteWindow.sv
source/indexedClassifier.sv
source/instrClassifier.sv
source/decodeResultRegs.sv
source/z80InstrDecoderTop.sv
tb/z80InstrDecoder_sva.sv
tb/tbZ80InstrDecoder.sv

// ==== tb/tbZ80InstrDecoder.sv ====
`timescale 1ns/1ps

module tbZ80InstrDecoder import z80DecodePkg::*; ();

    localparam int numTests = 10;
    localparam int watchdogNs = numTests * 200;
    localparam logic [addrWidth-1:0] unmappedAddr = 4'hC;

    logic                 pclk;
    logic                 rstN;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [addrWidth-1:0] paddr;
    logic [dataWidth-1:0] pwdata;
    logic [dataWidth-1:0] prdata;
    logic                 pready;
    logic                 pslverr;

    // stimulus table with the code word holding the bytes in memory order from the top
    string       names [numTests];
    logic [31:0] codes [numTests];
    int          byteNum [numTests];
    logic [3:0]  randMask [numTests];
    insnGroup    expGroup [numTests];
    int          expLen [numTests];
    int          tableSize = 0;

    integer seed;
    int     errorCount = 0;
    int     passCount = 0;
    bit     testFailed;

    z80InstrDecoderTop dut (
        .pclk    (pclk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    initial begin
        #(watchdogNs);
        $display("timeout: table did not finish within %0d ns", watchdogNs);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic addTest(input string name, input logic [31:0] code, input int n,
                           input logic [3:0] mask, input insnGroup grp, input int lenExp);
        names[tableSize] = name;
        codes[tableSize] = code;
        byteNum[tableSize] = n;
        randMask[tableSize] = mask;
        expGroup[tableSize] = grp;
        expLen[tableSize] = lenExp;
        tableSize++;
    endtask

    task automatic checkEqual(input string testName, input string field,
                              input int expected, input int actual);
        assert (actual == expected) else begin
            $display("mismatch %s %s: expected 0x%0h, actual 0x%0h",
                     testName, field, expected, actual);
            errorCount++;
            testFailed = 1'b1;
        end
    endtask

    task automatic checkTrue(input string testName, input bit cond, input string what);
        assert (cond) else begin
            $display("%s: %s", testName, what);
            errorCount++;
            testFailed = 1'b1;
        end
    endtask

    // called with SETUP already driven and returns 1 ns after the closing edge
    task automatic accessPhase(output logic [dataWidth-1:0] data, output logic err);
        @(posedge pclk);
        #1;
        penable = 1'b1;
        @(negedge pclk);
        data = prdata;
        err = pslverr;
        checkTrue("apb", pready, "pready was low in an ACCESS cycle");
        @(posedge pclk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [addrWidth-1:0] addr,
                            input logic [dataWidth-1:0] data, output logic err);
        logic [dataWidth-1:0] unused;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        accessPhase(unused, err);
        pwrite = 1'b0;
    endtask

    task automatic apbRead(input logic [addrWidth-1:0] addr,
                           output logic [dataWidth-1:0] data, output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        accessPhase(data, err);
    endtask

    task automatic runTest(input int idx);
        logic [7:0]           insnBytes [windowBytes];
        logic [dataWidth-1:0] rd;
        logic [dataWidth-1:0] held;
        logic                 err;
        string                nm;
        nm = names[idx];
        testFailed = 1'b0;
        for (int i = 0; i < windowBytes; i++) begin
            if (randMask[idx][i])
                insnBytes[i] = 8'($random(seed));
            else
                insnBytes[i] = codes[idx][31-8*i -: 8];
        end
        for (int i = 0; i < byteNum[idx]; i++) begin
            apbWrite(regByte, {24'd0, insnBytes[i]}, err);
            checkTrue(nm, !err, "byte write raised pslverr");
            if (i == 0 && byteNum[idx] > 1) begin
                apbRead(regResult, rd, err);
                checkEqual(nm, "done after first byte", 0, int'(rd[16]));
            end
        end
        apbRead(regResult, rd, err);
        checkTrue(nm, !err, "result read raised pslverr");
        checkEqual(nm, "group", int'(expGroup[idx]), int'(rd[7:0]));
        checkEqual(nm, "length", expLen[idx], int'(rd[10:8]));
        checkEqual(nm, "done", 1, int'(rd[16]));
        // result word bits outside group, length and done read as zero
        checkEqual(nm, "unused result bits", 0, int'(rd & 32'hFFFE_F800));
        held = rd;
        // both writes must be refused and leave the result alone
        apbWrite(regByte, {24'd0, 8'($random(seed))}, err);
        checkTrue(nm, err, "byte write while done was not refused");
        apbWrite(unmappedAddr, 32'd0, err);
        checkTrue(nm, err, "write to an unmapped address was not refused");
        apbRead(regResult, rd, err);
        checkEqual(nm, "result after refusals", int'(held), int'(rd));
        apbWrite(regAck, 32'd0, err);
        checkTrue(nm, !err, "acknowledge raised pslverr");
        apbRead(regResult, rd, err);
        checkEqual(nm, "done after ack", 0, int'(rd[16]));
        checkEqual(nm, "byte count after ack", 0, int'(dut.uWindow.byteCount));
        if (testFailed) begin
            $display("test %0d %s: FAIL", idx, nm);
        end else begin
            $display("test %0d %s: pass", idx, nm);
            passCount++;
        end
    endtask

    initial begin
        logic [dataWidth-1:0] rd;
        logic                 err;
        rstN = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        seed = 32'h91e1_5ae8;
        // mask bit i set means slot i is an operand or unused and gets a random byte
        addTest("nop", 32'h00000000, 1, 4'b1110, nop, 1);
        addTest("ld hl,nn", 32'h21000000, 3, 4'b1110, ldDdNn, 3);
        addTest("bit 0,(hl)", 32'hCB460000, 2, 4'b1100, bitIndHl, 2);
        addTest("set 0,a", 32'hCBC70000, 2, 4'b1100, setReg, 2);
        addTest("ld a,(ix+d)", 32'hDD7E0000, 3, 4'b1100, ldRegIdx, 3);
        addTest("ld iy,nn", 32'hFD210000, 4, 4'b1100, ldIxiyNn, 4);
        addTest("set 1,(ix+d)", 32'hDDCB00CE, 4, 4'b0100, setIdx, 4);
        addTest("byte d3", 32'hD3000000, 1, 4'b1110, illegal, 1);
        addTest("neg", 32'hED440000, 2, 4'b1100, edUnsupported, 2);
        addTest("dd 00", 32'hDD000000, 2, 4'b1100, illegal, 2);
        repeat (4) @(posedge pclk);
        #1;
        rstN = 1'b1;
        checkTrue("reset", !pslverr, "pslverr high after reset");
        apbRead(regResult, rd, err);
        checkEqual("reset", "done", 0, int'(rd[16]));
        checkEqual("reset", "byte count", 0, int'(dut.uWindow.byteCount));
        for (int t = 0; t < tableSize; t++) begin
            runTest(t);
        end
        $display("summary: %0d tests, %0d passed, %0d check errors, %0d assertion failures",
                 tableSize, passCount, errorCount, dut.sva.assertFails);
        if (errorCount == 0 && dut.sva.assertFails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tb/z80InstrDecoder_sva.sv ====
`timescale 1ns/1ps

module z80InstrDecoderSva import z80DecodePkg::*; (
    input logic                 pclk,
    input logic                 rstN,
    input logic                 psel,
    input logic                 penable,
    input logic                 pwrite,
    input logic [addrWidth-1:0] paddr,
    input logic                 pslverr,
    input logic [lenWidth-1:0]  byteCount,
    input logic [lenWidth-1:0]  len,
    input logic                 done,
    input logic                 ackPulse
);

    int   assertFails = 0;
    logic acceptedWrite;

    assign acceptedWrite = psel && penable && pwrite && (paddr == regByte) && !done
        && (byteCount < lenWidth'(windowBytes));

    errOnlyInAccess: assert property (@(posedge pclk) disable iff (!rstN)
        pslverr |-> (psel && penable))
        else begin
            $error("pslverr high outside an ACCESS cycle");
            assertFails++;
        end

    // byte count has just reached the decoded length
    doneNotEarly: assert property (@(posedge pclk) disable iff (!rstN)
        ($past(acceptedWrite) && (byteCount >= len)) |-> !done)
        else begin
            $error("done rose together with the completing write");
            assertFails++;
        end

    doneOneCycleLater: assert property (@(posedge pclk) disable iff (!rstN)
        ($past(acceptedWrite) && (byteCount >= len)) |=> done)
        else begin
            $error("done missing one cycle after the completing write");
            assertFails++;
        end

    ackClearsDone: assert property (@(posedge pclk) disable iff (!rstN)
        ackPulse |=> !done)
        else begin
            $error("done still high after an acknowledge");
            assertFails++;
        end

    countInRange: assert property (@(posedge pclk) disable iff (!rstN)
        byteCount <= lenWidth'(windowBytes))
        else begin
            $error("byte count beyond the window size");
            assertFails++;
        end

endmodule

// window and result registers meet in the top level
bind z80InstrDecoderTop z80InstrDecoderSva sva (
    .pclk      (pclk),
    .rstN      (rstN),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pslverr   (pslverr),
    .byteCount (byteCount),
    .len       (len),
    .done      (done),
    .ackPulse  (ackPulse)
);
